// File: dv/keccak_properties.sv
/*
 * Handshake and output assertions for the Keccak-512 core.
 * Bound into keccak, sees the padder to permutation link directly.
 */
`timescale 1ns/1ps

module keccak_properties (
    input logic                               clk,
    input logic                               f_out_ready,
    input logic                               buffer_full,
    input logic                               block_valid,
    input logic                               block_ack,
    input logic [keccak_pkg::DIGEST_BITS-1:0] out,
    input logic                               out_ready
);

    // Digest flag is sticky until reset
    a_ready_sticky: assert property (@(posedge clk) disable iff (f_out_ready)
        out_ready |=> out_ready)
        else $error("out_ready fell without a reset");

    // Digest frozen once flagged
    a_out_stable: assert property (@(posedge clk) disable iff (f_out_ready)
        out_ready |=> $stable(out))
        else $error("out changed while out_ready was high");

    // Offered block stays up until the permutation takes it
    a_block_hold: assert property (@(posedge clk) disable iff (f_out_ready)
        block_valid && !block_ack |=> block_valid)
        else $error("block_valid dropped before block_ack");

    // Back-pressure released right after the ack
    a_full_release: assert property (@(posedge clk) disable iff (f_out_ready)
        block_ack |=> !buffer_full)
        else $error("buffer_full still high one cycle after block_ack");

endmodule

bind keccak keccak_properties u_keccak_properties (
    .clk        (clk),
    .f_out_ready(f_out_ready),
    .buffer_full(buffer_full),
    .block_valid(block_valid),
    .block_ack  (block_ack),
    .out        (out),
    .out_ready  (out_ready)
);

// File: dv/keccak_ref_model.svh
/*
 * Reference model of Keccak-512 for the testbench.
 * Pads a byte message with the original Keccak rule, runs Keccak-f[1600]
 * per block and returns the digest with byte 0 in the top byte.
 * Included inside the testbench module body.
 */
`ifndef KECCAK_REF_MODEL_SVH
`define KECCAK_REF_MODEL_SVH

typedef logic [7:0] byte_q_t [$];
typedef logic [24:0][63:0] lanes_t;

// Rate in bytes for a 1024-bit capacity
localparam int MODEL_RATE_BYTES = 72;

// Lane rotate left
function automatic logic [63:0] lane_rotl(input logic [63:0] v, input int n);
    if (n == 0)
        return v;
    return (v << n) | (v >> (64 - n));
endfunction

// One output bit of the degree-8 LFSR behind the iota constants
function automatic logic lfsr_rc_bit(input int t);
    logic [8:0] r;
    r = 9'h001;
    for (int i = 0; i < t % 255; i++)
    begin
        r = {r[7:0], 1'b0};
        r[0] = r[0] ^ r[8];
        r[4] = r[4] ^ r[8];
        r[5] = r[5] ^ r[8];
        r[6] = r[6] ^ r[8];
        r[8] = 1'b0;
    end
    return r[0];
endfunction

// Iota constant of round ir, bits at positions 2^j - 1
function automatic logic [63:0] iota_constant(input int ir);
    logic [63:0] rc;
    rc = '0;
    for (int j = 0; j < 7; j++)
        rc[(1 << j) - 1] = lfsr_rc_bit(j + 7 * ir);
    return rc;
endfunction

// Rho amount from the (x,y) walk starting at lane (1,0)
function automatic int rho_offset(input int lane);
    int x;
    int y;
    int nx;
    int r;
    x = 1;
    y = 0;
    r = 0;
    for (int t = 0; t < 24; t++)
    begin
        if (x + 5 * y == lane)
            r = ((t + 1) * (t + 2) / 2) % 64;
        nx = y;
        y = (2 * x + 3 * y) % 5;
        x = nx;
    end
    return r;
endfunction

// Keccak-f[1600], lane index x + 5y
function automatic lanes_t keccak_f(input lanes_t a);
    logic [63:0] c [5];
    logic [63:0] d [5];
    lanes_t b;
    for (int ir = 0; ir < 24; ir++)
    begin
        // Theta
        for (int x = 0; x < 5; x++)
            c[x] = a[x] ^ a[x + 5] ^ a[x + 10] ^ a[x + 15] ^ a[x + 20];
        for (int x = 0; x < 5; x++)
            d[x] = c[(x + 4) % 5] ^ lane_rotl(c[(x + 1) % 5], 1);
        for (int i = 0; i < 25; i++)
            a[i] = a[i] ^ d[i % 5];
        // Rho and pi, lane (x,y) lands on (y, 2x+3y)
        for (int x = 0; x < 5; x++)
            for (int y = 0; y < 5; y++)
                b[y + 5 * ((2 * x + 3 * y) % 5)] = lane_rotl(a[x + 5 * y], rho_offset(x + 5 * y));
        // Chi
        for (int x = 0; x < 5; x++)
            for (int y = 0; y < 5; y++)
                a[x + 5 * y] = b[x + 5 * y] ^ (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
        // Iota
        a[0] = a[0] ^ iota_constant(ir);
    end
    return a;
endfunction

// Whole hash of a byte message
function automatic logic [511:0] expected_digest(input byte_q_t data);
    byte_q_t padded;
    lanes_t st;
    logic [63:0] lane;
    logic [511:0] dig;
    int blocks;
    padded = data;
    padded.push_back(8'h01);
    while (padded.size() % MODEL_RATE_BYTES != 0)
        padded.push_back(8'h00);
    // 0x80 merges with 0x01 when both hit the last byte
    padded[padded.size() - 1] = padded[padded.size() - 1] | 8'h80;
    st = '0;
    blocks = padded.size() / MODEL_RATE_BYTES;
    for (int bl = 0; bl < blocks; bl++)
    begin
        // Little-endian lanes, nine per block
        for (int i = 0; i < 9; i++)
        begin
            for (int k = 0; k < 8; k++)
                lane[8 * k +: 8] = padded[MODEL_RATE_BYTES * bl + 8 * i + k];
            st[i] = st[i] ^ lane;
        end
        st = keccak_f(st);
    end
    for (int i = 0; i < 64; i++)
        dig[511 - 8 * i -: 8] = st[i / 8][8 * (i % 8) +: 8];
    return dig;
endfunction

`endif

// File: dv/keccak_tb.sv
/*
 * Testbench for the Keccak-512 core.
 * Streams random messages with random in_ready gaps, honors buffer_full,
 * and checks out against the reference model, the out_ready latency and
 * the hold of the digest. One message per reset.
 */
`timescale 1ns/1ps

module keccak_tb;
    import keccak_pkg::*;

    `include "keccak_ref_model.svh"

    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES = 20;
    localparam int LAST_TO_READY = 26;
    localparam int READY_WAIT = 100;
    localparam int SILENT_WORDS = 19;
    localparam int SILENT_WATCH = 40;

    logic                   clk = 1'b0;
    logic                   f_out_ready;
    logic [31:0]            in_data;
    logic                   in_ready;
    logic                   is_last;
    logic [1:0]             byte_num;
    logic                   buffer_full;
    logic [DIGEST_BITS-1:0] out;
    logic                   out_ready;

    int          error_count = 0;
    int          test_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int unsigned discard;
    int          test_len [$];
    byte_q_t     msg;

    keccak DUT (
        .clk        (clk),
        .f_out_ready(f_out_ready),
        .in         (in_data),
        .in_ready   (in_ready),
        .is_last    (is_last),
        .byte_num   (byte_num),
        .buffer_full(buffer_full),
        .out        (out),
        .out_ready  (out_ready)
    );

    always #CLK_HALF clk = ~clk;

    // Guard against a hung handshake
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // Cycle allowance of one message
    function automatic int cycle_budget(input int words, input int blocks);
        return blocks * 30 + words * 4 + 50;
    endfunction

    // Called at edge plus 2 ns, returns at edge plus 2 ns
    task automatic apply_reset;
        f_out_ready = 1'b1;
        in_ready = 1'b0;
        is_last = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        f_out_ready = 1'b0;
        if (buffer_full || out_ready)
        begin
            error_count++;
            $display("ERROR: buffer_full or out_ready high right after reset");
        end
    endtask

    task automatic check_not_ready;
        if (out_ready)
        begin
            error_count++;
            $display("ERROR: out_ready high before the digest was complete");
        end
    endtask

    // Random idle gap, then hold the word until buffer_full lets it in
    task automatic drive_word(input logic [31:0] word, input logic last, input logic [1:0] bn);
        int   gap;
        logic taken;
        gap = $urandom_range(3, 0);
        repeat (gap)
        begin
            @(posedge clk);
            #2;
            check_not_ready();
        end
        in_data = word;
        is_last = last;
        byte_num = bn;
        in_ready = 1'b1;
        taken = 1'b0;
        while (!taken)
        begin
            // buffer_full only moves on the edge, this is what the DUT sees
            taken = !buffer_full;
            @(posedge clk);
            #2;
            check_not_ready();
        end
        in_ready = 1'b0;
        is_last = 1'b0;
        in_data = $urandom;
    endtask

    task automatic run_message(input int len);
        int                     words;
        int                     n;
        logic [31:0]            word;
        logic [DIGEST_BITS-1:0] expected;
        logic [DIGEST_BITS-1:0] held;
        msg.delete();
        for (int i = 0; i < len; i++)
            msg.push_back(8'($urandom));
        // Lengths divisible by 4 end with an empty last word
        words = len / 4 + 1;
        for (int w = 0; w < words; w++)
        begin
            word = $urandom;
            for (int k = 0; k < 4; k++)
                if (4 * w + k < len)
                    word[31 - 8 * k -: 8] = msg[4 * w + k];
            if (w == words - 1)
                drive_word(word, 1'b1, 2'(len % 4));
            else
                drive_word(word, 1'b0, 2'd0);
        end
        n = 0;
        while (!out_ready && n < READY_WAIT)
        begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!out_ready)
        begin
            error_count++;
            $display("ERROR: out_ready never rose for a %0d byte message", len);
        end
        else
        begin
            // Single block messages see an idle permutation
            if (len < MODEL_RATE_BYTES && n != LAST_TO_READY)
            begin
                error_count++;
                $display("MISMATCH out_ready latency expected %h got %h", LAST_TO_READY, n);
            end
            expected = expected_digest(msg);
            if (out !== expected)
            begin
                error_count++;
                $display("MISMATCH out (len %0d) expected %h got %h", len, expected, out);
            end
            held = out;
            repeat (HOLD_CYCLES)
            begin
                @(posedge clk);
                #2;
                if (!out_ready)
                begin
                    error_count++;
                    $display("ERROR: out_ready fell before reset");
                end
                if (out !== held)
                begin
                    error_count++;
                    $display("MISMATCH out hold expected %h got %h", held, out);
                end
            end
        end
        test_count++;
        apply_reset();
    endtask

    // Full words but no is_last, the digest must never appear
    task automatic run_without_last;
        int n;
        for (int w = 0; w < SILENT_WORDS; w++)
            drive_word($urandom, 1'b0, 2'd0);
        n = 0;
        repeat (SILENT_WATCH)
        begin
            @(posedge clk);
            #2;
            if (out_ready)
                n++;
        end
        if (n != 0)
        begin
            error_count++;
            $display("ERROR: out_ready rose although no last word was sent");
        end
        test_count++;
        apply_reset();
    endtask

    initial
    begin
        discard = $urandom(32'h1648_c073);
        f_out_ready = 1'b1;
        in_data = '0;
        in_ready = 1'b0;
        is_last = 1'b0;
        byte_num = 2'd0;
        // Empty, short, merged pad byte, extra pad block, two blocks
        test_len = '{0, 1, 2, 3, 4, 5, 6, 7, 13, 34, 55, 68, 70, 71, 72, 144};
        repeat (3)
            test_len.push_back($urandom_range(70, 1));
        repeat (6)
            test_len.push_back($urandom_range(300, 73));
        cycle_limit = RESET_CYCLES;
        foreach (test_len[i])
            cycle_limit += cycle_budget(test_len[i] / 4 + 1, test_len[i] / MODEL_RATE_BYTES + 1);
        cycle_limit += cycle_budget(SILENT_WORDS, 2);

        apply_reset();
        foreach (test_len[i])
            run_message(test_len[i]);
        run_without_last();

        $display("Errors: %0d over %0d tests", error_count, test_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
rtl/keccak_pkg.sv
rtl/padder.sv
rtl/round_constant.sv
rtl/keccak_round.sv
rtl/f_permutation.sv
rtl/keccak.sv
dv/keccak_properties.sv
dv/keccak_tb.sv

// File: rtl/f_permutation.sv
/*
 * Keccak-f[1600] sequencer with the 1600-bit sponge state.
 * An idle permutation XORs the offered block into the top 576 bits and acks
 * it, then runs 24 rounds, one per cycle. perm_done pulses with the final
 * state, 24 cycles after block_ack.
 */
`timescale 1ns/1ps

module f_permutation (
    input  logic                              clk,
    input  logic                              f_out_ready,
    input  logic [keccak_pkg::RATE_BITS-1:0]  block,
    input  logic                              block_valid,
    output logic                              block_ack,
    output logic [keccak_pkg::STATE_BITS-1:0] state_out,
    output logic                              perm_done
);
    import keccak_pkg::*;

    keccak_state_u state;
    keccak_state_u round_out;
    logic [63:0]   rc;
    logic [4:0]    round_idx;
    logic          busy;

    round_constant u_round_constant (
        .round_idx(round_idx),
        .rc       (rc)
    );

    keccak_round u_keccak_round (
        .state_in (state),
        .rc       (rc),
        .state_out(round_out)
    );

    // Sponge state and round sequencer
    always_ff @(posedge clk or posedge f_out_ready)
    begin
        if (f_out_ready)
        begin
            state.flat <= '0;
            busy <= 1'b0;
            round_idx <= '0;
            block_ack <= 1'b0;
            perm_done <= 1'b0;
        end
        else
        begin
            // Both strobes last a single cycle
            block_ack <= 1'b0;
            perm_done <= 1'b0;
            if (busy)
            begin
                state <= round_out;
                if (round_idx == 5'(NUM_ROUNDS - 1))
                begin
                    // Counter wraps and state holds the permuted block
                    round_idx <= '0;
                    busy <= 1'b0;
                    perm_done <= 1'b1;
                end
                else
                begin
                    round_idx <= round_idx + 5'd1;
                end
            end
            else if (block_valid)
            begin
                // Absorb into the rate part (lanes 0 to 8)
                state.flat[STATE_BITS-1 -: RATE_BITS] <=
                    state.flat[STATE_BITS-1 -: RATE_BITS] ^ block;
                busy <= 1'b1;
                block_ack <= 1'b1;
            end
        end
    end

    assign state_out = state.flat;

endmodule

// File: rtl/keccak.sv
/*
 * Keccak-512 hash core, one message per reset.
 * Words stream in big-endian through the padder, blocks are byte-swapped
 * per 64-bit lane into the permutation, and the digest is swapped back.
 * out_ready rises once the final padded block has been permuted.
 */
`timescale 1ns/1ps

module keccak (
    input  logic                               clk,
    input  logic                               f_out_ready,
    input  logic [31:0]                        in,
    input  logic                               in_ready,
    input  logic                               is_last,
    input  logic [1:0]                         byte_num,
    output logic                               buffer_full,
    output logic [keccak_pkg::DIGEST_BITS-1:0] out,
    output logic                               out_ready
);
    import keccak_pkg::*;

    logic [RATE_BITS-1:0]   padder_block;
    logic [RATE_BITS-1:0]   perm_block;
    logic                   block_valid;
    logic                   last_block;
    logic                   block_ack;
    logic [STATE_BITS-1:0]  state_flat;
    logic                   perm_done;
    logic [DIGEST_BITS-1:0] digest_raw;
    // Last word seen, then final block taken by the permutation
    logic                   msg_end;
    logic                   final_acked;

    padder u_padder (
        .clk        (clk),
        .f_out_ready(f_out_ready),
        .in         (in),
        .in_ready   (in_ready),
        .is_last    (is_last),
        .byte_num   (byte_num),
        .block_ack  (block_ack),
        .buffer_full(buffer_full),
        .block      (padder_block),
        .block_valid(block_valid),
        .last_block (last_block)
    );

    f_permutation u_f_permutation (
        .clk        (clk),
        .f_out_ready(f_out_ready),
        .block      (perm_block),
        .block_valid(block_valid),
        .block_ack  (block_ack),
        .state_out  (state_flat),
        .perm_done  (perm_done)
    );

    // First message byte becomes the low byte of lane 0
    for (genvar w = 0; w < RATE_BITS / 64; w++)
    begin : g_in_lane
        for (genvar b = 0; b < 8; b++)
        begin : g_in_byte
            assign perm_block[w*64 + b*8 +: 8] = padder_block[w*64 + (7-b)*8 +: 8];
        end
    end

    // Digest is lanes 0 to 7, swapped back to byte stream order
    assign digest_raw = state_flat[STATE_BITS-1 -: DIGEST_BITS];

    for (genvar w = 0; w < DIGEST_BITS / 64; w++)
    begin : g_out_lane
        for (genvar b = 0; b < 8; b++)
        begin : g_out_byte
            assign out[w*64 + b*8 +: 8] = digest_raw[w*64 + (7-b)*8 +: 8];
        end
    end

    always_ff @(posedge clk or posedge f_out_ready)
    begin
        if (f_out_ready)
        begin
            msg_end <= 1'b0;
            final_acked <= 1'b0;
            out_ready <= 1'b0;
        end
        else
        begin
            if (in_ready && !buffer_full && is_last)
            begin
                msg_end <= 1'b1;
            end
            // Earlier blocks may still be in flight, so wait for the ack
            if (msg_end && block_ack && last_block)
            begin
                final_acked <= 1'b1;
            end
            // Sticky until the next reset
            if (final_acked && perm_done)
            begin
                out_ready <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/keccak_pkg.sv
/*
 * Shared sizes and types for the Keccak-512 core.
 * The state union gives a flat view for absorbing and digest extraction
 * and a lane view for the round steps. Lane (x,y) sits at lanes[y][x],
 * and lane (0,0) occupies the most significant 64 bits of the flat word.
 */
package keccak_pkg;

    // Permutation and sponge sizes for Keccak-512
    localparam int STATE_BITS = 1600;
    localparam int RATE_BITS = 576;
    localparam int DIGEST_BITS = 512;
    localparam int NUM_ROUNDS = 24;

    // 32-bit user words needed to fill one rate block
    localparam int WORDS_PER_BLOCK = RATE_BITS / 32;

    // One state word, two decodings
    typedef union packed {
        logic [STATE_BITS-1:0] flat;
        logic [0:4][0:4][63:0] lanes;
    } keccak_state_u;

    // Rho rotation amounts, indexed by 5*y + x
    localparam int RHO_OFFSETS [25] = '{
        // y = 0
        0, 1, 62, 28, 27,
        // y = 1
        36, 44, 6, 55, 20,
        // y = 2
        3, 10, 43, 25, 39,
        // y = 3
        41, 45, 15, 21, 8,
        // y = 4
        18, 2, 61, 56, 14
    };

endpackage

// File: rtl/keccak_round.sv
/*
 * One combinational round of Keccak-f[1600] on the lane view.
 * Steps run theta, rho, pi, chi, iota; rc is the constant of this round.
 * Instantiated once and iterated by the permutation sequencer.
 */
`timescale 1ns/1ps

module keccak_round (
    input  keccak_pkg::keccak_state_u state_in,
    input  logic [63:0]               rc,
    output keccak_pkg::keccak_state_u state_out
);
    import keccak_pkg::*;

    // Column parities and theta mix per column x
    logic [63:0] c [5];
    logic [63:0] d [5];
    // Lane arrays indexed [y][x]
    logic [63:0] t [5][5];
    logic [63:0] b [5][5];
    logic [63:0] chi [5][5];

    // Rotate left, n from 0 to 63
    function automatic logic [63:0] rotl(input logic [63:0] v, input int n);
        logic [127:0] w;
        w = {v, v} << n;
        return w[127:64];
    endfunction

    // Theta parity and mix
    for (genvar x = 0; x < 5; x++)
    begin : g_col
        assign c[x] = state_in.lanes[0][x] ^ state_in.lanes[1][x]
                    ^ state_in.lanes[2][x] ^ state_in.lanes[3][x]
                    ^ state_in.lanes[4][x];
        assign d[x] = c[(x + 4) % 5] ^ rotl(c[(x + 1) % 5], 1);
    end

    for (genvar y = 0; y < 5; y++)
    begin : g_row
        for (genvar x = 0; x < 5; x++)
        begin : g_lane
            localparam int ROT = RHO_OFFSETS[5 * y + x];

            // Theta applied to every lane
            assign t[y][x] = state_in.lanes[y][x] ^ d[x];

            // Rho rotates, pi moves lane (x,y) to (y, 2x+3y)
            assign b[(2 * x + 3 * y) % 5][y] = rotl(t[y][x], ROT);

            // Chi mixes along the row
            assign chi[y][x] = b[y][x] ^ (~b[y][(x + 1) % 5] & b[y][(x + 2) % 5]);
        end
    end

    // Gather lanes, iota touches lane (0,0) only
    always_comb
    begin
        for (int y = 0; y < 5; y++)
        begin
            for (int x = 0; x < 5; x++)
            begin
                state_out.lanes[y][x] = chi[y][x];
            end
        end
        state_out.lanes[0][0] = chi[0][0] ^ rc;
    end

endmodule

// File: rtl/padder.sv
/*
 * Gathers 32-bit big-endian input words into 576-bit rate blocks.
 * The last word carries the 0x01 pad byte after its valid bytes, the rest
 * of the block is zero filled and 0x80 is ORed into the final byte.
 * A 72-byte message ends with a word of zero bytes, which opens a fresh
 * block that holds only padding.
 */
`timescale 1ns/1ps

module padder (
    input  logic                           clk,
    input  logic                           f_out_ready,
    input  logic [31:0]                    in,
    input  logic                           in_ready,
    input  logic                           is_last,
    input  logic [1:0]                     byte_num,
    input  logic                           block_ack,
    output logic                           buffer_full,
    output logic [keccak_pkg::RATE_BITS-1:0] block,
    output logic                           block_valid,
    output logic                           last_block
);
    import keccak_pkg::*;

    logic [4:0]           word_cnt;
    logic                 done;
    logic                 take;
    logic [31:0]          pad_word;
    logic [RATE_BITS-1:0] appended;
    logic [RATE_BITS-1:0] closed;

    // Words accepted only while no block is waiting for the permutation
    assign take = in_ready && !block_valid && !done;
    assign buffer_full = block_valid;

    // Pad byte goes right after the valid bytes of the final word
    always_comb
    begin
        case (byte_num)
            2'd0:    pad_word = 32'h0100_0000;
            2'd1:    pad_word = {in[31:24], 24'h01_0000};
            2'd2:    pad_word = {in[31:16], 16'h0100};
            default: pad_word = {in[31:8], 8'h01};
        endcase
    end

    // Shift the new word in at the bottom
    assign appended = {block[RATE_BITS-33:0], is_last ? pad_word : in};

    // Push the words to the top, zero fill below, closing 0x80 at the end
    // 0x01 and 0x80 merge into 0x81 when the last word has three bytes
    // and is the 18th word of the block
    assign closed = (appended << (32 * (WORDS_PER_BLOCK - 1 - int'(word_cnt))))
                  | {{(RATE_BITS - 8){1'b0}}, 8'h80};

    // Control state
    always_ff @(posedge clk or posedge f_out_ready)
    begin
        if (f_out_ready)
        begin
            word_cnt <= '0;
            block_valid <= 1'b0;
            last_block <= 1'b0;
            done <= 1'b0;
        end
        else if (block_ack)
        begin
            // Permutation has the block, start a new one
            block_valid <= 1'b0;
            last_block <= 1'b0;
            word_cnt <= '0;
        end
        else if (take)
        begin
            if (is_last)
            begin
                block_valid <= 1'b1;
                last_block <= 1'b1;
                done <= 1'b1;
            end
            else if (word_cnt == 5'(WORDS_PER_BLOCK - 1))
            begin
                // Full block of message words, no padding yet
                block_valid <= 1'b1;
            end
            else
            begin
                word_cnt <= word_cnt + 5'd1;
            end
        end
    end

    // Block payload, stable while block_valid is high
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            block <= is_last ? closed : appended;
        end
    end

endmodule

// File: rtl/round_constant.sv
/*
 * Iota round constants of Keccak-f[1600].
 * Pure lookup from the round index, zero outside the 24 valid rounds.
 */
`timescale 1ns/1ps

module round_constant (
    input  logic [4:0]  round_idx,
    output logic [63:0] rc
);
    import keccak_pkg::*;

    always_comb
    begin
        if (int'(round_idx) >= NUM_ROUNDS)
        begin
            rc = 64'h0;
        end
        else
        begin
            case (round_idx)
                5'd0:    rc = 64'h0000_0000_0000_0001;
                5'd1:    rc = 64'h0000_0000_0000_8082;
                5'd2:    rc = 64'h8000_0000_0000_808A;
                5'd3:    rc = 64'h8000_0000_8000_8000;
                5'd4:    rc = 64'h0000_0000_0000_808B;
                5'd5:    rc = 64'h0000_0000_8000_0001;
                5'd6:    rc = 64'h8000_0000_8000_8081;
                5'd7:    rc = 64'h8000_0000_0000_8009;
                5'd8:    rc = 64'h0000_0000_0000_008A;
                5'd9:    rc = 64'h0000_0000_0000_0088;
                5'd10:   rc = 64'h0000_0000_8000_8009;
                5'd11:   rc = 64'h0000_0000_8000_000A;
                5'd12:   rc = 64'h0000_0000_8000_808B;
                5'd13:   rc = 64'h8000_0000_0000_008B;
                5'd14:   rc = 64'h8000_0000_0000_8089;
                5'd15:   rc = 64'h8000_0000_0000_8003;
                5'd16:   rc = 64'h8000_0000_0000_8002;
                5'd17:   rc = 64'h8000_0000_0000_0080;
                5'd18:   rc = 64'h0000_0000_0000_800A;
                5'd19:   rc = 64'h8000_0000_8000_000A;
                5'd20:   rc = 64'h8000_0000_8000_8081;
                5'd21:   rc = 64'h8000_0000_0000_8080;
                5'd22:   rc = 64'h0000_0000_8000_0001;
                default: rc = 64'h8000_0000_8000_8008;
            endcase
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the Keccak-512 testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module keccak_tb \
    -f filelist.f -o Vkeccak_tb \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vkeccak_tb > sim.log 2>&1
sim_status=$?
cat sim.log
[ "$sim_status" -eq 0 ] || exit 1
grep -q "Simulation failed" sim.log && exit 1 || exit 0
